/* include/mem_access_settings.svh */
// Word width settings for the data memory port, included by the RTL and the testbench
`ifndef MEM_ACCESS_SETTINGS_SVH
`define MEM_ACCESS_SETTINGS_SVH

// Data and address width in bits, 16, 32 or 64
`define MEM_WORD_SIZE 16

// Bytes held in one memory word
`define MEM_WORD_BYTES (`MEM_WORD_SIZE / 8)

// Low byte address bits that pick a lane inside the word
`define MEM_LANE_BITS $clog2(`MEM_WORD_BYTES)

`endif

/* logic/mem_access_pkg.sv */
// Shared types of the data memory port: access size and the two state machines
package mem_access_pkg;

    // Access size as log2 of the byte count
    typedef enum logic [1:0] {
        SIZE_1 = 2'd0,
        SIZE_2 = 2'd1,
        SIZE_4 = 2'd2,
        SIZE_8 = 2'd3
    } access_size_e;

    // Alignment fixer FSM
    typedef enum logic [2:0] {
        FX_IDLE,
        FX_READ_WAIT,
        FX_MERGE_WRITE,
        FX_WRITE_WAIT,
        FX_REPLY
    } fixer_state_e;

    // RAM pin sequencer FSM
    typedef enum logic [1:0] {
        SQ_IDLE,
        SQ_READ_ISSUE,
        SQ_READ_CAPTURE,
        SQ_WRITE_ISSUE
    } seq_state_e;

endpackage

/* logic/mem_word_if.sv */
// Word-wide transaction channel from the alignment fixer to the RAM pin sequencer
`timescale 1ns/1ps

`include "mem_access_settings.svh"

interface mem_word_if;

    // Word address, already stripped of the lane bits
    logic [`MEM_WORD_SIZE-1:0] addr;
    logic [`MEM_WORD_SIZE-1:0] wdata;
    logic [`MEM_WORD_SIZE-1:0] rdata;

    // Held until ready, then low for at least one cycle
    logic read;
    logic write;

    // Single cycle completion pulse
    logic ready;

    modport requester (
        output addr,
        output wdata,
        output read,
        output write,
        input  rdata,
        input  ready
    );

    modport responder (
        input  addr,
        input  wdata,
        input  read,
        input  write,
        output rdata,
        output ready
    );

endinterface

/* logic/access_width_ctrl.sv */
// Byte-mode flag and access size decode feeding the alignment fixer
`timescale 1ns/1ps

`include "mem_access_settings.svh"

module access_width_ctrl (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         enable,
    input  logic                         toggle_byte_mode,
    input  logic [1:0]                   reduced_behaviour_bits,
    input  logic                         force_aligned_use,
    output mem_access_pkg::access_size_e access_size
);

    localparam mem_access_pkg::access_size_e FULL_SIZE =
        mem_access_pkg::access_size_e'(`MEM_LANE_BITS);

    logic                         byte_mode;
    mem_access_pkg::access_size_e req_size;

    // CPU controlled byte mode, flips once per enabled toggle
    always_ff @(posedge clk)
    begin
        if (!reset)
            byte_mode <= 1'b0;
        else if (enable && toggle_byte_mode)
            byte_mode <= !byte_mode;
    end

    // Force aligned wins over byte mode, byte mode over the reduced bits
    always_comb
    begin
        if (force_aligned_use)
            req_size = FULL_SIZE;
        else if (byte_mode)
            req_size = mem_access_pkg::SIZE_1;
        else
        begin
            case (reduced_behaviour_bits)
                2'b00:   req_size = FULL_SIZE;
                2'b01:   req_size = mem_access_pkg::SIZE_4;
                2'b10:   req_size = mem_access_pkg::SIZE_2;
                default: req_size = mem_access_pkg::SIZE_1;
            endcase
        end
    end

    // Nothing wider than one word reaches the fixer
    assign access_size = (req_size > FULL_SIZE) ? FULL_SIZE : req_size;

endmodule

/* logic/alignment_fixer.sv */
// Alignment check, load lane extraction and sub-word store read-modify-write
`timescale 1ns/1ps

`include "mem_access_settings.svh"

module alignment_fixer (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         enable,
    input  mem_access_pkg::access_size_e access_size,
    input  logic [`MEM_WORD_SIZE-1:0]    cpu_addr,
    input  logic [`MEM_WORD_SIZE-1:0]    cpu_data_out,
    input  logic                         cpu_read_en,
    input  logic                         cpu_write_en,
    output logic [`MEM_WORD_SIZE-1:0]    cpu_data_in,
    output logic                         cpu_ready,
    output logic                         alignment_error,
    mem_word_if.requester                mem
);

    mem_access_pkg::fixer_state_e state;
    mem_access_pkg::access_size_e size_q;
    logic                         store_q;

    logic [`MEM_LANE_BITS-1:0]    lane;
    logic [`MEM_LANE_BITS+2:0]    lane_shift;
    logic [`MEM_WORD_BYTES-1:0]   byte_en;
    logic [`MEM_WORD_SIZE-1:0]    size_mask;
    logic [`MEM_WORD_SIZE-1:0]    lane_mask;
    logic [`MEM_WORD_SIZE-1:0]    merged_word;
    logic                         misaligned;
    logic                         full_word;
    logic                         mem_done;

    // Byte lane of the request, the address is held until cpu_ready
    assign lane       = cpu_addr[`MEM_LANE_BITS-1:0];
    assign lane_shift = {lane, 3'b000};

    // Any lane bit below the access size set means misaligned
    assign misaligned = |(lane & ~({`MEM_LANE_BITS{1'b1}} << access_size));
    assign full_word  = (int'(access_size) == `MEM_LANE_BITS);

    // Bytes covered by the latched size, counted from lane 0
    assign byte_en = ~({`MEM_WORD_BYTES{1'b1}} << (1 << size_q));

    always_comb
    begin
        for (int i = 0; i < `MEM_WORD_BYTES; i++)
        begin
            size_mask[i*8 +: 8] = {8{byte_en[i]}};
        end
    end

    assign lane_mask = size_mask << lane_shift;

    // New bytes go into their lane, the neighbours come from the read word
    assign merged_word = (mem.rdata & ~lane_mask) | ((cpu_data_out << lane_shift) & lane_mask);

    // Loads shift the lane down and zero-extend it
    assign cpu_data_in = (mem.rdata >> lane_shift) & size_mask;

    // A load ends on the read, a store on its write
    assign mem_done = mem.ready
                      && ((state == mem_access_pkg::FX_READ_WAIT && !store_q)
                          || state == mem_access_pkg::FX_WRITE_WAIT);

    assign cpu_ready = mem_done || (state == mem_access_pkg::FX_REPLY);

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            state           <= mem_access_pkg::FX_IDLE;
            mem.read        <= 1'b0;
            mem.write       <= 1'b0;
            alignment_error <= 1'b0;
        end
        else
        begin
            case (state)
                mem_access_pkg::FX_IDLE:
                begin
                    if (enable && (cpu_read_en || cpu_write_en))
                    begin
                        if (misaligned)
                        begin
                            alignment_error <= 1'b1;
                            state           <= mem_access_pkg::FX_REPLY;
                        end
                        else if (cpu_write_en && full_word)
                        begin
                            mem.write <= 1'b1;
                            state     <= mem_access_pkg::FX_WRITE_WAIT;
                        end
                        else
                        begin
                            // Loads and sub-word stores both start with a read
                            mem.read <= 1'b1;
                            state    <= mem_access_pkg::FX_READ_WAIT;
                        end
                    end
                end
                mem_access_pkg::FX_READ_WAIT:
                begin
                    if (mem.ready)
                    begin
                        mem.read <= 1'b0;
                        if (store_q)
                            state <= mem_access_pkg::FX_MERGE_WRITE;
                        else
                            state <= mem_access_pkg::FX_IDLE;
                    end
                end
                mem_access_pkg::FX_MERGE_WRITE:
                begin
                    // Read dropped for this cycle, merged word already latched
                    mem.write <= 1'b1;
                    state     <= mem_access_pkg::FX_WRITE_WAIT;
                end
                mem_access_pkg::FX_WRITE_WAIT:
                begin
                    if (mem.ready)
                    begin
                        mem.write <= 1'b0;
                        state     <= mem_access_pkg::FX_IDLE;
                    end
                end
                mem_access_pkg::FX_REPLY:
                begin
                    alignment_error <= 1'b0;
                    state           <= mem_access_pkg::FX_IDLE;
                end
                default:
                    state <= mem_access_pkg::FX_IDLE;
            endcase
        end
    end

    // Request payload, captured while idle
    always_ff @(posedge clk)
    begin
        if (state == mem_access_pkg::FX_IDLE)
        begin
            mem.addr  <= cpu_addr >> `MEM_LANE_BITS;
            mem.wdata <= cpu_data_out;
            size_q    <= access_size;
            store_q   <= cpu_write_en;
        end
        else if (state == mem_access_pkg::FX_READ_WAIT && mem.ready)
            mem.wdata <= merged_word;
    end

    a_read_write_exclusive: assert property (
        @(posedge clk) disable iff (!reset) !(mem.read && mem.write)
    );

    a_error_with_ready: assert property (
        @(posedge clk) disable iff (!reset) alignment_error |-> cpu_ready
    );

endmodule

/* logic/mem_port_sequencer.sv */
// Drives the synchronous RAM pins for one word transaction at a time
`timescale 1ns/1ps

`include "mem_access_settings.svh"

module mem_port_sequencer (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [`MEM_WORD_SIZE-1:0] mem_data_in,
    output logic [`MEM_WORD_SIZE-1:0] mem_addr,
    output logic [`MEM_WORD_SIZE-1:0] mem_data_out,
    output logic                      mem_write_en,
    mem_word_if.responder             port
);

    mem_access_pkg::seq_state_e state;

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            state        <= mem_access_pkg::SQ_IDLE;
            mem_write_en <= 1'b0;
            port.ready   <= 1'b0;
        end
        else
        begin
            port.ready   <= 1'b0;
            mem_write_en <= 1'b0;
            case (state)
                mem_access_pkg::SQ_IDLE:
                begin
                    // The requester still holds read or write during the ready cycle
                    if (!port.ready)
                    begin
                        if (port.write)
                        begin
                            mem_write_en <= 1'b1;
                            state        <= mem_access_pkg::SQ_WRITE_ISSUE;
                        end
                        else if (port.read)
                            state <= mem_access_pkg::SQ_READ_ISSUE;
                    end
                end
                mem_access_pkg::SQ_READ_ISSUE:
                    // RAM samples the address at the end of this cycle
                    state <= mem_access_pkg::SQ_READ_CAPTURE;
                mem_access_pkg::SQ_READ_CAPTURE:
                begin
                    port.ready <= 1'b1;
                    state      <= mem_access_pkg::SQ_IDLE;
                end
                mem_access_pkg::SQ_WRITE_ISSUE:
                begin
                    port.ready <= 1'b1;
                    state      <= mem_access_pkg::SQ_IDLE;
                end
                default:
                    state <= mem_access_pkg::SQ_IDLE;
            endcase
        end
    end

    // Address and data follow the channel until a transaction starts
    always_ff @(posedge clk)
    begin
        if (state == mem_access_pkg::SQ_IDLE)
        begin
            mem_addr     <= port.addr;
            mem_data_out <= port.wdata;
        end
        if (state == mem_access_pkg::SQ_READ_CAPTURE)
            port.rdata <= mem_data_in;
    end

    a_write_single_cycle: assert property (
        @(posedge clk) disable iff (!reset) mem_write_en |=> !mem_write_en
    );

    a_ready_single_pulse: assert property (
        @(posedge clk) disable iff (!reset) port.ready |=> !port.ready
    );

endmodule

/* logic/cpu_mem_interface.sv */
// Top level of the data memory port, CPU request side to external RAM pins
`timescale 1ns/1ps

`include "mem_access_settings.svh"

module cpu_mem_interface (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      enable,
    input  logic                      toggle_byte_mode,
    input  logic [1:0]                reduced_behaviour_bits,
    input  logic                      force_aligned_use,
    output logic                      alignment_error,
    // CPU side
    input  logic [`MEM_WORD_SIZE-1:0] cpu_addr,
    input  logic [`MEM_WORD_SIZE-1:0] cpu_data_out,
    output logic [`MEM_WORD_SIZE-1:0] cpu_data_in,
    input  logic                      cpu_write_en,
    input  logic                      cpu_read_en,
    output logic                      cpu_ready,
    // External RAM
    output logic [`MEM_WORD_SIZE-1:0] mem_addr,
    output logic [`MEM_WORD_SIZE-1:0] mem_data_out,
    input  logic [`MEM_WORD_SIZE-1:0] mem_data_in,
    output logic                      mem_write_en
);

    mem_access_pkg::access_size_e access_size;

    mem_word_if word_bus ();

    access_width_ctrl width_ctrl (
        .clk                    (clk),
        .reset                  (reset),
        .enable                 (enable),
        .toggle_byte_mode       (toggle_byte_mode),
        .reduced_behaviour_bits (reduced_behaviour_bits),
        .force_aligned_use      (force_aligned_use),
        .access_size            (access_size)
    );

    alignment_fixer fixer (
        .clk             (clk),
        .reset           (reset),
        .enable          (enable),
        .access_size     (access_size),
        .cpu_addr        (cpu_addr),
        .cpu_data_out    (cpu_data_out),
        .cpu_read_en     (cpu_read_en),
        .cpu_write_en    (cpu_write_en),
        .cpu_data_in     (cpu_data_in),
        .cpu_ready       (cpu_ready),
        .alignment_error (alignment_error),
        .mem             (word_bus.requester)
    );

    mem_port_sequencer sequencer (
        .clk          (clk),
        .reset        (reset),
        .mem_data_in  (mem_data_in),
        .mem_addr     (mem_addr),
        .mem_data_out (mem_data_out),
        .mem_write_en (mem_write_en),
        .port         (word_bus.responder)
    );

endmodule

/* tests/clock_gen.sv */
// Free-running testbench clock with a 4 ns period, instantiated by the testbench top
`timescale 1ns/1ps

module clock_gen (
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever
            #2 clk = ~clk;
    end

endmodule

/* tests/cpu_mem_interface_tb.sv */
// Random-stimulus testbench for the data memory port, run as the simulation top
`timescale 1ns/1ps

`include "mem_access_settings.svh"

module cpu_mem_interface_tb;

    localparam int W       = `MEM_WORD_SIZE;
    localparam int BYTES   = `MEM_WORD_BYTES;
    localparam int LANES   = `MEM_LANE_BITS;
    localparam int WORDS   = 256;
    localparam int TIMEOUT = 50;

    typedef logic [W-1:0] word_t;

    logic       clk;
    logic       reset, enable, toggle_byte_mode, force_aligned_use;
    logic       cpu_write_en, cpu_read_en, cpu_ready, alignment_error, mem_write_en;
    logic [1:0] reduced_behaviour_bits;
    word_t      cpu_addr, cpu_data_out, cpu_data_in, mem_addr, mem_data_out;
    word_t      mem_data_in = '0;

    word_t       ram [WORDS];
    logic [7:0]  ref_bytes [WORDS*BYTES];
    int unsigned write_count;
    logic        byte_mode_model;

    clock_gen clk_src (.clk(clk));

    cpu_mem_interface DUT (.*);

    // Little-endian view of the expected memory with the size as log2 bytes
    function automatic word_t ref_read(int unsigned addr, int size);
        word_t value;
        value = '0;
        for (int i = 0; i < (1 << size); i++)
            value[i*8 +: 8] = ref_bytes[addr + i];
        return value;
    endfunction

    function automatic void ref_write(int unsigned addr, int size, word_t data);
        for (int i = 0; i < (1 << size); i++)
            ref_bytes[addr + i] = data[i*8 +: 8];
    endfunction

    // Force beats byte mode and byte mode beats the reduced bits
    function automatic int expected_size(logic [1:0] bits, logic force_full);
        int size;
        if (force_full)
            size = LANES;
        else if (byte_mode_model)
            size = 0;
        else if (bits == 2'b00)
            size = LANES;
        else
            size = 3 - int'(bits);
        return (size > LANES) ? LANES : size;
    endfunction

    function automatic word_t rand_word();
        return word_t'({$urandom, $urandom});
    endfunction

    // External RAM with a one cycle read latency
    // Contents come from the reference during reset
    always @(posedge clk)
    begin
        if (!reset)
        begin
            write_count <= 0;
            for (int w = 0; w < WORDS; w++)
                ram[w] <= ref_read(w * BYTES, LANES);
        end
        else
        begin
            mem_data_in <= ram[mem_addr[7:0]];
            if (mem_write_en)
            begin
                ram[mem_addr[7:0]] <= mem_data_out;
                write_count        <= write_count + 1;
            end
        end
    end

    task automatic check_value(string name, word_t expected, word_t actual);
        if (expected !== actual)
        begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            $display("** FAIL **");
            $fatal(1, "Check %s failed", name);
        end
    endtask

    task automatic fail_with(string reason);
        $display("%s", reason);
        $display("** FAIL **");
        $fatal(1, "%s", reason);
    endtask

    task automatic start_request(logic is_write, int unsigned addr, word_t data,
                                 logic [1:0] bits, logic force_full);
        cpu_addr               <= word_t'(addr);
        cpu_data_out           <= data;
        cpu_write_en           <= is_write;
        cpu_read_en            <= !is_write;
        reduced_behaviour_bits <= bits;
        force_aligned_use      <= force_full;
    endtask

    task automatic wait_ready(string name);
        int cycles;
        cycles = 0;
        do
        begin
            @(posedge clk);
            cycles++;
        end
        while (!cpu_ready && cycles < TIMEOUT);
        if (!cpu_ready)
            fail_with($sformatf("No cpu_ready within %0d cycles during %s", TIMEOUT, name));
    endtask

    // Enables low for one cycle between requests
    task automatic finish_request();
        cpu_read_en  <= 1'b0;
        cpu_write_en <= 1'b0;
        @(posedge clk);
    endtask

    task automatic toggle_pulse();
        toggle_byte_mode <= 1'b1;
        @(posedge clk);
        if (enable)
            byte_mode_model = !byte_mode_model;
        toggle_byte_mode <= 1'b0;
    endtask

    task automatic access_checked(string name, logic is_write, int unsigned addr, word_t data,
                                  logic [1:0] bits, logic force_full);
        int          size;
        logic        misaligned;
        int unsigned writes_before;
        size          = expected_size(bits, force_full);
        misaligned    = (addr % (1 << size)) != 0;
        writes_before = write_count;
        start_request(is_write, addr, data, bits, force_full);
        wait_ready(name);
        check_value({name, " alignment_error"}, word_t'(misaligned), word_t'(alignment_error));
        if (misaligned)
            check_value({name, " write count"}, word_t'(writes_before), word_t'(write_count));
        else if (is_write)
            ref_write(addr, size, data);
        else
            check_value(name, ref_read(addr, size), cpu_data_in);
        finish_request();
    endtask

    initial
    begin
        int unsigned addr;
        int unsigned writes;
        int          size;
        logic [1:0]  bits;
        word_t       data;
        void'($urandom(32'h05a8_fcba));
        for (int i = 0; i < WORDS * BYTES; i++)
            ref_bytes[i] = 8'($urandom);
        byte_mode_model = 1'b0;
        reset                  <= 1'b0;
        enable                 <= 1'b0;
        toggle_byte_mode       <= 1'b0;
        force_aligned_use      <= 1'b0;
        reduced_behaviour_bits <= 2'b00;
        cpu_addr               <= '0;
        cpu_data_out           <= '0;
        cpu_write_en           <= 1'b0;
        cpu_read_en            <= 1'b0;
        repeat (3) @(posedge clk);
        reset  <= 1'b1;
        enable <= 1'b1;
        @(posedge clk);
        check_value("reset cpu_ready", '0, word_t'(cpu_ready));
        check_value("reset alignment_error", '0, word_t'(alignment_error));
        check_value("reset mem_write_en", '0, word_t'(mem_write_en));

        for (int n = 0; n < 40; n++)
        begin
            addr = ($urandom % WORDS) * BYTES;
            access_checked("full word", 1'($urandom), addr, rand_word(), 2'b00, 1'b0);
        end

        // Sub-word stores followed by word and lane readback
        for (int b = 3; b >= 2; b--)
        begin
            bits = 2'(b);
            size = expected_size(bits, 1'b0);
            if (size < LANES)
            begin
                for (int n = 0; n < 30; n++)
                begin
                    addr = ($urandom % (WORDS * BYTES)) & ~((1 << size) - 1);
                    access_checked("sized store", 1'b1, addr, rand_word(), bits, 1'b0);
                    access_checked("word after merge", 1'b0, addr & ~(BYTES - 1), '0,
                                   2'b00, 1'b0);
                    access_checked("sized load", 1'b0, addr, '0, bits, 1'b0);
                end
            end
        end

        for (int n = 0; n < 20; n++)
        begin
            addr = ($urandom % (WORDS * BYTES)) | 1;
            access_checked("misaligned", 1'($urandom), addr, rand_word(), 2'($urandom % 3), 1'b0);
            access_checked("word after misaligned", 1'b0, addr & ~(BYTES - 1), '0, 2'b00, 1'b0);
        end

        // Byte mode switched on and flipped a few more times
        toggle_pulse();
        access_checked("byte mode probe", 1'b0, addr, '0, 2'b00, 1'b0);
        for (int n = 0; n < 20; n++)
        begin
            addr = $urandom % (WORDS * BYTES);
            access_checked("byte mode store", 1'b1, addr, rand_word(), 2'($urandom), 1'b0);
            access_checked("forced word load", 1'b0, addr & ~(BYTES - 1), '0, 2'($urandom), 1'b1);
            access_checked("forced misaligned", 1'b0, addr | 1, '0, 2'b11, 1'b1);
            if (n % 5 == 4)
                toggle_pulse();
        end

        // Store held while disabled and released afterwards
        enable <= 1'b0;
        writes = write_count;
        data   = rand_word();
        addr   = ($urandom % WORDS) * BYTES;
        start_request(1'b1, addr, data, 2'b00, 1'b1);
        repeat (20)
        begin
            @(posedge clk);
            check_value("gated cpu_ready", '0, word_t'(cpu_ready));
        end
        toggle_pulse();
        check_value("gated write count", word_t'(writes), word_t'(write_count));
        enable <= 1'b1;
        wait_ready("gated store");
        check_value("gated alignment_error", '0, word_t'(alignment_error));
        ref_write(addr, LANES, data);
        finish_request();
        access_checked("gated readback", 1'b0, addr, '0, 2'b00, 1'b1);
        access_checked("byte mode after gated toggle", 1'b0, addr + 1, '0, 2'b00, 1'b0);

        $display("** PASS **");
        $finish;
    end

endmodule

/* sources.f */
+incdir+include
logic/mem_access_pkg.sv
logic/mem_word_if.sv
logic/access_width_ctrl.sv
logic/alignment_fixer.sv
logic/mem_port_sequencer.sv
logic/cpu_mem_interface.sv
tests/clock_gen.sv
tests/cpu_mem_interface_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and judge the result from the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module cpu_mem_interface_tb \
    -f sources.f \
    -o cpu_mem_interface_sim

./obj_dir/cpu_mem_interface_sim | tee sim.log

if grep -q -F '** FAIL **' sim.log; then
    echo "Simulation failed"
    exit 1
fi
if ! grep -q -F '** PASS **' sim.log; then
    echo "Simulation ended without a pass line"
    exit 1
fi
echo "Simulation passed"
